// ==== src/scalar_pkg.sv ====
////////////////////
// Shared widths, opcode encodings and types for the scalar unit.
// Every stage imports this package by wildcard in its module header.
////////////////////
`default_nettype none

package scalar_pkg;

	localparam int data_width     = 32;
	localparam int instr_width    = 32;
	localparam int reg_addr_width = 4;
	localparam int num_regs       = 16;
	localparam int op_field_width = 2;
	localparam int imm_width      = instr_width - 1 - 3*op_field_width - 3*reg_addr_width;

	////////////////////
	// Opcode fields
	localparam logic [op_field_width-1:0] op_type_alu  = 2'b00;
	localparam logic [op_field_width-1:0] op_type_ctrl = 2'b01;
	localparam logic [op_field_width-1:0] class_arith  = 2'b00;
	localparam logic [op_field_width-1:0] class_imm    = 2'b01;
	localparam logic [op_field_width-1:0] class_move   = 2'b11;
	localparam logic [op_field_width-1:0] class_halt   = 2'b01;
	localparam logic [op_field_width-1:0] code_add     = 2'b00;
	localparam logic [op_field_width-1:0] code_sub     = 2'b01;
	localparam logic [op_field_width-1:0] code_and     = 2'b10;
	localparam logic [op_field_width-1:0] code_or      = 2'b11;
	localparam logic [op_field_width-1:0] code_mov_in  = 2'b10;
	localparam logic [op_field_width-1:0] code_mov_out = 2'b11;
	localparam logic [op_field_width-1:0] code_halt    = 2'b11;

	////////////////////
	// Types
	typedef logic [data_width-1:0]     data_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	typedef struct packed {
		logic                      sel_unit;
		logic [op_field_width-1:0] op_type;
		logic [op_field_width-1:0] op_class;
		logic [op_field_width-1:0] op_code;
		reg_addr_t                 dst;
		reg_addr_t                 src1;
		reg_addr_t                 src2;
		logic [imm_width-1:0]      imm;
	} instr_t;

	// Nine operations, so the encoding needs four bits
	typedef enum logic [3:0] {
		exe_add, exe_sub, exe_and, exe_or, exe_addi,
		exe_mov_in, exe_mov_out, exe_halt, exe_nop
	} exe_op_t;

	typedef struct packed {
		logic zero;
		logic negative;
	} status_t;

	// Operations that write the register file
	function automatic logic op_writes_reg(exe_op_t op);
		return op inside {exe_add, exe_sub, exe_and, exe_or, exe_addi, exe_mov_in};
	endfunction

	function automatic logic op_sets_status(exe_op_t op);
		return op inside {exe_add, exe_sub, exe_and, exe_or, exe_addi};
	endfunction

endpackage

`default_nettype wire

// ==== src/scalar_reg_file.sv ====
////////////////////
// Scalar register file, 16 words.
// Two combinational read ports, one write port on the clock edge.
////////////////////
`timescale 1ns/10ps
`default_nettype none

module scalar_reg_file
	import scalar_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t rd_addr1,
	input  reg_addr_t rd_addr2,
	output data_t     rd_data1,
	output data_t     rd_data2,
	input  logic      we,
	input  reg_addr_t waddr,
	input  data_t     wdata
);

	data_t regs [num_regs];

	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end
		else if (we) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== src/scalar_decode.sv ====
////////////////////
// Decode stage.
// Routes vector instructions to v_command, maps scalar opcodes to an
// execute operation and picks operands through the bypass paths.
////////////////////
`timescale 1ns/10ps
`default_nettype none

module scalar_decode
	import scalar_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      en,
	input  logic      instr_valid,
	input  instr_t    instr,
	output reg_addr_t rd_addr1,
	output reg_addr_t rd_addr2,
	input  data_t     rd_data1,
	input  data_t     rd_data2,
	input  logic      byp_ex_valid,
	input  reg_addr_t byp_ex_dst,
	input  data_t     byp_ex_data,
	input  logic      rf_we,
	input  reg_addr_t rf_waddr,
	input  data_t     rf_wdata,
	output logic      v_command_valid,
	output instr_t    v_command,
	output logic      ex_valid,
	output exe_op_t   ex_op,
	output reg_addr_t ex_dst,
	output data_t     ex_a,
	output data_t     ex_b
);

	exe_op_t dec_op;
	data_t   imm_ext;
	data_t   opnd_a;
	data_t   opnd_b;
	logic    take;

	assign take     = en & instr_valid;
	assign rd_addr1 = instr.src1;
	assign rd_addr2 = instr.src2;
	assign imm_ext  = {{(data_width-imm_width){instr.imm[imm_width-1]}}, instr.imm};

	always_comb begin
		dec_op = exe_nop;
		if (instr.op_type == op_type_alu) begin
			case (instr.op_class)
				class_arith: begin
					case (instr.op_code)
						code_add: dec_op = exe_add;
						code_sub: dec_op = exe_sub;
						code_and: dec_op = exe_and;
						default:  dec_op = exe_or;
					endcase
				end
				class_imm:  dec_op = exe_addi;
				class_move: begin
					if (instr.op_code == code_mov_in)
						dec_op = exe_mov_in;
					else if (instr.op_code == code_mov_out)
						dec_op = exe_mov_out;
				end
				default: dec_op = exe_nop;
			endcase
		end
		else if (instr.op_type == op_type_ctrl && instr.op_class == class_halt &&
				instr.op_code == code_halt) begin
			dec_op = exe_halt;
		end
	end

	////////////////////
	// Bypass, youngest result first
	assign opnd_a = (byp_ex_valid && byp_ex_dst == instr.src1) ? byp_ex_data :
			(rf_we && rf_waddr == instr.src1) ? rf_wdata : rd_data1;
	assign opnd_b = (dec_op == exe_addi) ? imm_ext :
			(byp_ex_valid && byp_ex_dst == instr.src2) ? byp_ex_data :
			(rf_we && rf_waddr == instr.src2) ? rf_wdata : rd_data2;

	always_ff @(posedge clock) begin
		if (reset) begin
			v_command_valid <= 1'b0;
			ex_valid        <= 1'b0;
			ex_op           <= exe_nop;
		end
		else begin
			v_command_valid <= take & instr.sel_unit;
			if (en) begin
				ex_valid <= instr_valid & ~instr.sel_unit;
				ex_op    <= dec_op;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take && instr.sel_unit)
			v_command <= instr;
		if (take && !instr.sel_unit) begin
			ex_dst <= instr.dst;
			ex_a   <= opnd_a;
			ex_b   <= opnd_b;
		end
	end

endmodule

`default_nettype wire

// ==== src/scalar_execute.sv ====
////////////////////
// Execute stage.
// ALU and register moves; the unregistered result also feeds the
// decode bypass so dependent instructions can issue back to back.
////////////////////
`timescale 1ns/10ps
`default_nettype none

module scalar_execute
	import scalar_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      en,
	input  logic      ex_valid,
	input  exe_op_t   ex_op,
	input  reg_addr_t ex_dst,
	input  data_t     ex_a,
	input  data_t     ex_b,
	input  data_t     scalar_data_in,
	output logic      fwd_valid,
	output reg_addr_t fwd_dst,
	output data_t     fwd_data,
	output logic      wb_valid,
	output exe_op_t   wb_op,
	output reg_addr_t wb_dst,
	output data_t     wb_data
);

	data_t result;

	always_comb begin
		case (ex_op)
			exe_add, exe_addi: result = ex_a + ex_b;
			exe_sub:           result = ex_a - ex_b;
			exe_and:           result = ex_a & ex_b;
			exe_or:            result = ex_a | ex_b;
			exe_mov_in:        result = scalar_data_in;
			exe_mov_out:       result = ex_a;
			default:           result = '0;
		endcase
	end

	assign fwd_valid = ex_valid & op_writes_reg(ex_op);
	assign fwd_dst   = ex_dst;
	assign fwd_data  = result;

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_op    <= exe_nop;
		end
		else if (en) begin
			wb_valid <= ex_valid;
			wb_op    <= ex_op;
		end
	end

	always_ff @(posedge clock) begin
		if (en) begin
			wb_dst  <= ex_dst;
			wb_data <= result;
		end
	end

endmodule

`default_nettype wire

// ==== src/scalar_result.sv ====
////////////////////
// Result stage.
// Writes the register file, keeps the status flags and the aux
// scalar register, and pulses term on halt.
////////////////////
`timescale 1ns/10ps
`default_nettype none

module scalar_result
	import scalar_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      en,
	input  logic      wb_valid,
	input  exe_op_t   wb_op,
	input  reg_addr_t wb_dst,
	input  data_t     wb_data,
	output logic      rf_we,
	output reg_addr_t rf_waddr,
	output data_t     rf_wdata,
	output data_t     scalar_data_out,
	output status_t   status,
	output logic      term
);

	logic commit;

	// Stage retires only on an enabled cycle
	assign commit   = en & wb_valid;

	assign rf_we    = commit & op_writes_reg(wb_op);
	assign rf_waddr = wb_dst;
	assign rf_wdata = wb_data;

	////////////////////
	// Status, aux register, term
	always_ff @(posedge clock) begin
		if (reset) begin
			status          <= '0;
			scalar_data_out <= '0;
			term            <= 1'b0;
		end
		else begin
			term <= commit & (wb_op == exe_halt);
			if (commit && op_sets_status(wb_op)) begin
				status.zero     <= (wb_data == '0);
				status.negative <= wb_data[data_width-1];
			end
			// Move to vector unit goes out through the aux register
			if (commit && wb_op == exe_mov_out)
				scalar_data_out <= wb_data;
		end
	end

endmodule

`default_nettype wire

// ==== src/scalar_unit.sv ====
////////////////////
// Scalar unit top level.
// Vector instructions leave as v_command, scalar ones run through
// decode, execute and result stages around a 16-entry register file.
////////////////////
`timescale 1ns/10ps
`default_nettype none

module scalar_unit
	import scalar_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    en,
	input  logic    instr_valid,
	input  instr_t  instr,
	input  data_t   scalar_data_in,
	output logic    v_command_valid,
	output instr_t  v_command,
	output data_t   scalar_data_out,
	output status_t status,
	output logic    term
);

	reg_addr_t rd_addr1;
	reg_addr_t rd_addr2;
	data_t     rd_data1;
	data_t     rd_data2;

	logic      ex_valid;
	exe_op_t   ex_op;
	reg_addr_t ex_dst;
	data_t     ex_a;
	data_t     ex_b;

	// Live result of the instruction now in execute
	logic      fwd_valid;
	reg_addr_t fwd_dst;
	data_t     fwd_data;

	logic      wb_valid;
	exe_op_t   wb_op;
	reg_addr_t wb_dst;
	data_t     wb_data;

	logic      rf_we;
	reg_addr_t rf_waddr;
	data_t     rf_wdata;

	scalar_decode decode0 (
		.clock(clock), .reset(reset), .en(en),
		.instr_valid(instr_valid), .instr(instr),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.rd_data1(rd_data1), .rd_data2(rd_data2),
		.byp_ex_valid(fwd_valid), .byp_ex_dst(fwd_dst), .byp_ex_data(fwd_data),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.v_command_valid(v_command_valid), .v_command(v_command),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_dst(ex_dst),
		.ex_a(ex_a), .ex_b(ex_b)
	);

	scalar_reg_file reg_file0 (
		.clock(clock), .reset(reset),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.rd_data1(rd_data1), .rd_data2(rd_data2),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	scalar_execute execute0 (
		.clock(clock), .reset(reset), .en(en),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_dst(ex_dst),
		.ex_a(ex_a), .ex_b(ex_b), .scalar_data_in(scalar_data_in),
		.fwd_valid(fwd_valid), .fwd_dst(fwd_dst), .fwd_data(fwd_data),
		.wb_valid(wb_valid), .wb_op(wb_op), .wb_dst(wb_dst), .wb_data(wb_data)
	);

	scalar_result result0 (
		.clock(clock), .reset(reset), .en(en),
		.wb_valid(wb_valid), .wb_op(wb_op), .wb_dst(wb_dst), .wb_data(wb_data),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.scalar_data_out(scalar_data_out), .status(status), .term(term)
	);

endmodule

`default_nettype wire

// ==== sim/scalar_unit_assert.sv ====
////////////////////
// Concurrent checks on the scalar unit outputs.
// Bound to every scalar_unit instance.
////////////////////
`timescale 1ns/10ps
`default_nettype none

module scalar_unit_assert
	import scalar_pkg::*;
(
	input logic    clock,
	input logic    reset,
	input logic    en,
	input logic    v_command_valid,
	input status_t status,
	input logic    term
);

	// Single-cycle halt pulse
	term_pulse: assert property (@(posedge clock) disable iff (reset) term |=> !term)
		else $error("term high on two cycles in a row");

	vcmd_reset: assert property (@(posedge clock) $past(reset) |-> !v_command_valid)
		else $error("v_command_valid high right after reset");

	// Flags move only on an enabled edge
	status_en: assert property (@(posedge clock) disable iff (reset)
			(status != $past(status)) |-> $past(en))
		else $error("status changed after an en-low cycle");

endmodule

bind scalar_unit scalar_unit_assert assert0 (
	.clock(clock), .reset(reset), .en(en),
	.v_command_valid(v_command_valid), .status(status), .term(term)
);

`default_nettype wire

// ==== sim/scalar_unit_tb.sv ====
////////////////////
// Testbench for the scalar unit.
// Reads kind, instruction, scalar_data_in and expected value per line
// from the input data file, issues each instruction and checks the
// outputs. The kind's high nibble is the test number and its low nibble
// the check.
////////////////////
`timescale 1ns/10ps
`default_nettype none

module scalar_unit_tb
	import scalar_pkg::*;
();

	logic    clock;
	logic    reset;
	logic    en;
	logic    instr_valid;
	instr_t  instr;
	data_t   scalar_data_in;
	logic    v_command_valid;
	instr_t  v_command;
	data_t   scalar_data_out;
	status_t status;
	logic    term;

	logic [31:0] stim [0:255];
	integer      seed;
	data_t       last_data;
	int          errors;
	int          checks;
	int          tests;
	int          test_errors;
	int          cur_test;

	scalar_unit dut0 (
		.clock(clock), .reset(reset), .en(en),
		.instr_valid(instr_valid), .instr(instr), .scalar_data_in(scalar_data_in),
		.v_command_valid(v_command_valid), .v_command(v_command),
		.scalar_data_out(scalar_data_out), .status(status), .term(term)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////
	// Drive helpers

	// Operand data lags its instruction by one edge, so it is present
	// while that instruction sits in execute
	task automatic issue(input instr_t word, input data_t data);
		@(posedge clock);
		en             <= 1'b1;
		instr_valid    <= 1'b1;
		instr          <= word;
		scalar_data_in <= last_data;
		last_data = data;
	endtask

	task automatic idle_cycle();
		@(posedge clock);
		en             <= 1'b1;
		instr_valid    <= 1'b0;
		scalar_data_in <= last_data;
		#1;
	endtask

	task automatic report_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
		errors++;
		test_errors++;
	endtask

	task automatic report_text(input string text);
		$display("ERROR at %0t: %s", $time, text);
		errors++;
		test_errors++;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		checks++;
		if (got !== exp)
			report_value(name, exp, got);
	endtask

	// Holds en low for n edges; held outputs must not move
	task automatic en_gap(input int n);
		data_t   hold_out;
		status_t hold_st;
		@(posedge clock);
		en             <= 1'b0;
		instr_valid    <= 1'b0;
		scalar_data_in <= last_data;
		#1;
		hold_out = scalar_data_out;
		hold_st  = status;
		repeat (n) begin
			@(posedge clock);
			#1;
			check_value("scalar_data_out", hold_out, scalar_data_out);
			check_value("status", {30'd0, hold_st}, {30'd0, status});
		end
	endtask

	////////////////////
	// Waits with timeout

	// Scalar results land three cycles after acceptance
	task automatic wait_data(input data_t exp);
		int n;
		n = 0;
		do begin
			idle_cycle();
			n++;
		end while ((scalar_data_out !== exp || n < 3) && n < 20);
		check_value("scalar_data_out", exp, scalar_data_out);
		checks++;
		if (scalar_data_out === exp && n != 3)
			report_text("scalar_data_out settled later than three cycles after acceptance");
	endtask

	task automatic wait_status(input status_t exp);
		int n;
		n = 0;
		do begin
			idle_cycle();
			n++;
		end while ((status !== exp || n < 3) && n < 20);
		check_value("status", {30'd0, exp}, {30'd0, status});
		checks++;
		if (status === exp && n != 3)
			report_text("status settled later than three cycles after acceptance");
	endtask

	task automatic wait_vector(input instr_t word);
		int n;
		n = 0;
		do begin
			idle_cycle();
			n++;
		end while (v_command_valid !== 1'b1 && n < 20);
		checks++;
		if (v_command_valid !== 1'b1)
			report_text("no vector command appeared within 20 cycles");
		else if (n != 1)
			report_text("vector command came later than one cycle after acceptance");
		check_value("v_command", word, v_command);
	endtask

	task automatic wait_term();
		int n;
		n = 0;
		do begin
			idle_cycle();
			n++;
		end while (term !== 1'b1 && n < 20);
		checks++;
		if (term !== 1'b1) begin
			report_text("term never pulsed after halt");
		end
		else begin
			if (n != 3)
				report_text("term pulsed other than three cycles after acceptance");
			idle_cycle();
			if (term !== 1'b0)
				report_text("term stayed high for more than one cycle");
		end
	endtask

	task automatic close_test();
		tests++;
		if (test_errors == 0)
			$display("test %0d passed", cur_test);
		else
			$display("test %0d failed with %0d errors", cur_test, test_errors);
	endtask

	////////////////////
	// Main sequence
	initial begin
		logic [31:0] kind;
		data_t       snap_out;
		status_t     snap_st;
		int          test_num;
		seed           = 32'ha94f;
		reset          = 1'b1;
		en             = 1'b0;
		instr_valid    = 1'b0;
		instr          = '0;
		scalar_data_in = '0;
		last_data      = '0;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		test_errors    = 0;
		cur_test       = 0;
		$readmemh("sim/scalar_unit_input.dat", stim);
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		idle_cycle();

		for (int i = 0; i < 64; i++) begin
			kind = stim[4*i];
			if (kind == 32'hff)
				break;
			test_num = int'(kind[7:4]);
			if (test_num != cur_test) begin
				if (cur_test != 0)
					close_test();
				cur_test    = test_num;
				test_errors = 0;
			end
			case (kind[3:0])
				4'h0: begin
					issue(stim[4*i+1], stim[4*i+2]);
					if (test_num == 6)
						en_gap(2 + ($unsigned($random(seed)) % 3));
				end
				4'h1: begin
					issue(stim[4*i+1], stim[4*i+2]);
					repeat (4) idle_cycle();
				end
				4'h2: begin
					issue(stim[4*i+1], stim[4*i+2]);
					wait_data(stim[4*i+3]);
				end
				4'h3: begin
					issue(stim[4*i+1], stim[4*i+2]);
					wait_status(stim[4*i+3][1:0]);
				end
				4'h4: begin
					snap_out = scalar_data_out;
					snap_st  = status;
					issue(stim[4*i+1], stim[4*i+2]);
					wait_vector(stim[4*i+1]);
					repeat (4) idle_cycle();
					check_value("scalar_data_out", snap_out, scalar_data_out);
					check_value("status", {30'd0, snap_st}, {30'd0, status});
				end
				default: begin
					issue(stim[4*i+1], stim[4*i+2]);
					wait_term();
				end
			endcase
		end
		if (cur_test != 0)
			close_test();
		repeat (3) idle_cycle();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/scalar_unit_input.dat ====
// kind (test nibble, check nibble) instr scalar_data_in expected
// check: 0 issue, 1 spaced issue, 2 data out, 3 status, 4 vector, 5 term
14 80624000 00000000 00000000
21 1C200000 0000F0F0 00000000
21 1C400000 00000FF0 00000000
21 00624000 00000000 00000000
22 1E060000 00000000 000100E0
21 02824000 00000000 00000000
22 1E080000 00000000 0000E100
21 04A24000 00000000 00000000
22 1E0A0000 00000000 000000F0
21 06C24000 00000000 00000000
22 1E0C0000 00000000 0000FFF0
21 08E21FF0 00000000 00000000
22 1E0E0000 00000000 0000F0E0
30 01024000 00000000 00000000
30 03304000 00000000 00000000
30 07530000 00000000 00000000
32 1E140000 00000000 0001F0F0
43 03622000 00000000 00000002
43 03842000 00000000 00000001
43 1DA00000 00000000 00000001
55 2E000000 00000000 00000000
60 1DC00000 12345678 00000000
60 09FC0005 00000000 00000000
62 1E1E0000 00000000 1234567D
FF 00000000 00000000 00000000

// ==== scalar_unit.f ====
src/scalar_pkg.sv
src/scalar_reg_file.sv
src/scalar_decode.sv
src/scalar_execute.sv
src/scalar_result.sv
src/scalar_unit.sv
sim/scalar_unit_assert.sv
sim/scalar_unit_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f scalar_unit.f \
		--top-module scalar_unit_tb -Mdir obj_dir

run: compile
	./obj_dir/Vscalar_unit_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Checks failed" sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
